// File: files.f
logic/region_pkg.sv
logic/lsu_demux.sv
logic/apb_mem_port.sv
logic/ram_arbiter.sv
logic/data_sram.sv
logic/lsu_apb_bridge.sv
logic/mem_region_top.sv
dv/tb_mem_region.sv

// File: Bender.yml
package:
  name: mem_region

sources:
  - logic/region_pkg.sv
  - logic/lsu_demux.sv
  - logic/apb_mem_port.sv
  - logic/ram_arbiter.sv
  - logic/data_sram.sv
  - logic/lsu_apb_bridge.sv
  - logic/mem_region_top.sv
  - target: test
    files:
      - dv/tb_mem_region.sv

// File: dv/tb_mem_region.sv
// directed testbench for mem_region_top; run from files.f with tb_mem_region as top
`timescale 1ns/1ps
`default_nettype none

module tb_mem_region;

  localparam int                                 RAM_BYTES      = 4096;
  localparam logic [region_pkg::REGION_HI_W-1:0] LOCAL_REGION   = 12'h001;
  localparam region_pkg::addr_t                  LOCAL_BASE     = {LOCAL_REGION, 20'h0};
  localparam int                                 TIMEOUT_CYCLES = 2000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              lsu_req_i;
  logic              lsu_gnt_o;
  logic              lsu_rvalid_o;
  region_pkg::addr_t lsu_addr_i;
  logic              lsu_we_i;
  region_pkg::strb_t lsu_be_i;
  region_pkg::word_t lsu_wdata_i;
  region_pkg::word_t lsu_rdata_o;
  logic              s_psel_i;
  logic              s_penable_i;
  region_pkg::addr_t s_paddr_i;
  logic              s_pwrite_i;
  region_pkg::word_t s_pwdata_i;
  region_pkg::strb_t s_pstrb_i;
  region_pkg::word_t s_prdata_o;
  logic              s_pready_o;
  logic              m_psel_o;
  logic              m_penable_o;
  region_pkg::addr_t m_paddr_o;
  logic              m_pwrite_o;
  region_pkg::word_t m_pwdata_o;
  region_pkg::strb_t m_pstrb_o;
  region_pkg::word_t m_prdata_i;
  logic              m_pready_i;

  int     errors = 0;
  int     cycle_count = 0;
  integer seed = 32'hecd7_8e9c;
  int     slv_wait;
  string  test_name = "init";

  // reference copies of the local RAM and of the external memory
  region_pkg::word_t ram_ref [RAM_BYTES/4];
  region_pkg::word_t ext_ref [region_pkg::addr_t];
  // memory of the behavioral APB slave on the master port
  region_pkg::word_t ext_mem [region_pkg::addr_t];

  // queued processor requests and their expected results
  region_pkg::addr_t q_addr [$];
  logic              q_we [$];
  region_pkg::strb_t q_be [$];
  region_pkg::word_t q_wdata [$];
  logic              q_local [$];
  region_pkg::word_t q_exp [$];
  // expected and observed transfers on the master port
  region_pkg::addr_t x_addr [$];
  logic              x_we [$];
  region_pkg::word_t x_wdata [$];
  region_pkg::strb_t x_strb [$];
  region_pkg::addr_t log_addr [$];
  logic              log_we [$];
  region_pkg::word_t log_wdata [$];
  region_pkg::strb_t log_strb [$];

  mem_region_top #(
    .DATA_RAM_SIZE (RAM_BYTES),
    .LOCAL_REGION  (LOCAL_REGION)
  ) mem_region_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_rdata_o  (lsu_rdata_o),
    .s_psel_i     (s_psel_i),
    .s_penable_i  (s_penable_i),
    .s_paddr_i    (s_paddr_i),
    .s_pwrite_i   (s_pwrite_i),
    .s_pwdata_i   (s_pwdata_i),
    .s_pstrb_i    (s_pstrb_i),
    .s_prdata_o   (s_prdata_o),
    .s_pready_o   (s_pready_o),
    .m_psel_o     (m_psel_o),
    .m_penable_o  (m_penable_o),
    .m_paddr_o    (m_paddr_o),
    .m_pwrite_o   (m_pwrite_o),
    .m_pwdata_o   (m_pwdata_o),
    .m_pstrb_o    (m_pstrb_o),
    .m_prdata_i   (m_prdata_i),
    .m_pready_i   (m_pready_i)
  );

  always
  begin
    #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles in test %s, %0d errors",
               cycle_count, test_name, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic region_pkg::word_t apply_strobes(input region_pkg::word_t old_w,
                                                      input region_pkg::word_t new_w,
                                                      input region_pkg::strb_t be);
    region_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < region_pkg::STRB_W; b++)
    begin
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // unwritten external words read as a pattern of their full address
  function automatic region_pkg::word_t ext_fill(input region_pkg::addr_t addr);
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  function automatic region_pkg::word_t ext_expect(input region_pkg::addr_t addr);
    return ext_ref.exists(addr) ? ext_ref[addr] : ext_fill(addr);
  endfunction

  function automatic region_pkg::word_t model_read(input region_pkg::addr_t addr);
    return ext_mem.exists(addr) ? ext_mem[addr] : ext_fill(addr);
  endfunction

  function automatic int ram_index(input region_pkg::addr_t addr);
    return (addr % RAM_BYTES) / region_pkg::STRB_W;
  endfunction

  // APB slave model with 0 to 3 random wait states
  task automatic complete_ext_transfer();
    m_pready_i <= 1'b1;
    if (m_pwrite_o)
    begin
      ext_mem[m_paddr_o] = apply_strobes(model_read(m_paddr_o), m_pwdata_o, m_pstrb_o);
      m_prdata_i <= '0;
    end
    else
      m_prdata_i <= model_read(m_paddr_o);
    log_addr.push_back(m_paddr_o);
    log_we.push_back(m_pwrite_o);
    log_wdata.push_back(m_pwdata_o);
    log_strb.push_back(m_pstrb_o);
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      m_pready_i <= 1'b0;
      slv_wait = 0;
    end
    else if (m_psel_o && !m_penable_o)
    begin
      slv_wait = $unsigned($random(seed)) % 4;
      if (slv_wait == 0)
        complete_ext_transfer();
    end
    else if (m_psel_o && m_penable_o)
    begin
      if (m_pready_i)
        m_pready_i <= 1'b0;
      else
      begin
        slv_wait = slv_wait - 1;
        if (slv_wait <= 0)
          complete_ext_transfer();
      end
    end
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("[ERROR] %s: %s", test_name, msg);
  endtask

  task automatic compare_word(input string what, input region_pkg::word_t exp,
                              input region_pkg::word_t act);
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_addr(input string what, input region_pkg::addr_t exp,
                              input region_pkg::addr_t act);
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_strb(input string what, input region_pkg::strb_t exp,
                              input region_pkg::strb_t act);
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // queue one processor access and work out its expected result
  task automatic lsu_push(input region_pkg::addr_t addr, input logic we,
                          input region_pkg::strb_t be, input region_pkg::word_t wdata);
    logic local_hit;
    int   idx;
    local_hit = (addr[region_pkg::ADDR_W-1 -: region_pkg::REGION_HI_W] == LOCAL_REGION);
    idx = ram_index(addr);
    q_addr.push_back(addr);
    q_we.push_back(we);
    q_be.push_back(be);
    q_wdata.push_back(wdata);
    q_local.push_back(local_hit);
    if (local_hit)
    begin
      if (we)
        ram_ref[idx] = apply_strobes(ram_ref[idx], wdata, be);
      q_exp.push_back(ram_ref[idx]);
    end
    else
    begin
      if (we)
        ext_ref[addr] = apply_strobes(ext_expect(addr), wdata, be);
      q_exp.push_back(ext_expect(addr));
      x_addr.push_back(addr);
      x_we.push_back(we);
      x_wdata.push_back(wdata);
      x_strb.push_back(we ? be : 4'b0000);
    end
  endtask

  task automatic drive_lsu(input int i);
    lsu_req_i   <= 1'b1;
    lsu_addr_i  <= q_addr[i];
    lsu_we_i    <= q_we[i];
    lsu_be_i    <= q_be[i];
    lsu_wdata_i <= q_wdata[i];
  endtask

  // issue the queued accesses back to back and check every response
  task automatic run_lsu_queue();
    int n_req;
    int issued;
    int done_cnt;
    int guard;
    int gnt_cyc [$];
    n_req = q_addr.size();
    issued = 0;
    done_cnt = 0;
    guard = 0;
    log_addr.delete();
    log_we.delete();
    log_wdata.delete();
    log_strb.delete();
    if (n_req > 0)
      drive_lsu(0);
    while (done_cnt < n_req && guard < 200)
    begin
      @(posedge clk);
      guard++;
      if (lsu_rvalid_o)
      begin
        if (done_cnt >= issued)
          report_failure("rvalid seen with no request outstanding");
        else
        begin
          if (q_local[done_cnt] && (cycle_count - gnt_cyc[done_cnt] != 1))
          begin
            errors++;
            $display("[ERROR] %s rvalid latency: expected 1, actual %0d", test_name,
                     cycle_count - gnt_cyc[done_cnt]);
          end
          if (!q_local[done_cnt] && !(m_penable_o && m_pready_i))
            report_failure("external rvalid outside the pready cycle");
          if (!q_we[done_cnt])
            compare_word("read data", q_exp[done_cnt], lsu_rdata_o);
        end
        done_cnt++;
      end
      if (lsu_req_i && lsu_gnt_o)
      begin
        gnt_cyc.push_back(cycle_count);
        issued++;
        if (issued < n_req)
          drive_lsu(issued);
        else
          lsu_req_i <= 1'b0;
      end
    end
    lsu_req_i <= 1'b0;
    if (done_cnt < n_req)
      report_failure("processor request never got its rvalid");
    if (log_addr.size() != x_addr.size())
    begin
      errors++;
      $display("[ERROR] %s master port transfers: expected %0d, actual %0d", test_name,
               x_addr.size(), log_addr.size());
    end
    else
    begin
      for (int i = 0; i < x_addr.size(); i++)
      begin
        compare_addr("paddr", x_addr[i], log_addr[i]);
        compare_strb("pstrb", x_strb[i], log_strb[i]);
        compare_bit("pwrite", x_we[i], log_we[i]);
        if (x_we[i])
          compare_word("pwdata", x_wdata[i], log_wdata[i]);
      end
    end
    q_addr.delete();
    q_we.delete();
    q_be.delete();
    q_wdata.delete();
    q_local.delete();
    q_exp.delete();
    x_addr.delete();
    x_we.delete();
    x_wdata.delete();
    x_strb.delete();
  endtask

  // one APB transfer into the RAM, pready expected in the second access cycle
  task automatic apb_xfer(input region_pkg::addr_t addr, input logic wr,
                          input region_pkg::word_t wdata, input region_pkg::strb_t strb,
                          output region_pkg::word_t rdata);
    int acc;
    s_psel_i    <= 1'b1;
    s_penable_i <= 1'b0;
    s_paddr_i   <= addr;
    s_pwrite_i  <= wr;
    s_pwdata_i  <= wdata;
    s_pstrb_i   <= strb;
    @(posedge clk);
    s_penable_i <= 1'b1;
    acc = 0;
    do
    begin
      @(posedge clk);
      acc++;
    end
    while (!s_pready_o && acc < 10);
    rdata = s_prdata_o;
    if (!s_pready_o)
      report_failure("APB slave port never raised pready");
    else if (acc != 2)
    begin
      errors++;
      $display("[ERROR] %s pready access cycle: expected 2, actual %0d", test_name, acc);
    end
    if (wr)
      ram_ref[ram_index(addr)] = apply_strobes(ram_ref[ram_index(addr)], wdata, strb);
    s_psel_i    <= 1'b0;
    s_penable_i <= 1'b0;
  endtask

  task automatic check_reset_state();
    test_name = "reset";
    @(posedge clk);
    if (lsu_rvalid_o !== 1'b0)
      report_failure("lsu_rvalid_o is not low after reset");
    if (s_pready_o !== 1'b0)
      report_failure("s_pready_o is not low after reset");
    if (m_psel_o !== 1'b0 || m_penable_o !== 1'b0)
      report_failure("master port psel or penable is not low after reset");
  endtask

  task automatic local_ram_bytes();
    test_name = "local_ram";
    lsu_push(LOCAL_BASE + 'h10, 1'b1, 4'b1111, 32'h1122_3344);
    lsu_push(LOCAL_BASE + 'h14, 1'b1, 4'b1111, 32'h5566_7788);
    lsu_push(LOCAL_BASE + 'h18, 1'b1, 4'b1111, 32'h99aa_bbcc);
    lsu_push(LOCAL_BASE + 'h1c, 1'b1, 4'b1111, 32'hddee_ff00);
    lsu_push(LOCAL_BASE + 'h10, 1'b1, 4'b0001, 32'haaaa_aa55);
    lsu_push(LOCAL_BASE + 'h14, 1'b1, 4'b0110, 32'hbbcc_ddee);
    lsu_push(LOCAL_BASE + 'h18, 1'b1, 4'b1000, 32'h99ff_ffff);
    lsu_push(LOCAL_BASE + 'h1c, 1'b1, 4'b1010, 32'h7700_6600);
    // back-to-back reads
    for (int i = 0; i < 4; i++)
      lsu_push(LOCAL_BASE + 'h10 + 4*i, 1'b0, 4'b1111, '0);
    run_lsu_queue();
  endtask

  task automatic shared_memory();
    region_pkg::word_t rd;
    test_name = "shared_mem";
    apb_xfer('h200, 1'b1, 32'hdead_beef, 4'b1111, rd);
    apb_xfer('h200, 1'b1, 32'h0000_4400, 4'b0010, rd);
    lsu_push(LOCAL_BASE + 'h200, 1'b0, 4'b1111, '0);
    run_lsu_queue();
    lsu_push(LOCAL_BASE + 'h204, 1'b1, 4'b1111, 32'h0bad_f00d);
    run_lsu_queue();
    apb_xfer('h204, 1'b0, '0, 4'b0000, rd);
    compare_word("APB read data", ram_ref[ram_index('h204)], rd);
  endtask

  task automatic external_region();
    test_name = "external";
    lsu_push(32'h2000_0100, 1'b1, 4'b1111, 32'h0102_0304);
    lsu_push(32'h2000_0104, 1'b1, 4'b0110, 32'hc0de_d00d);
    lsu_push(32'h2000_0100, 1'b0, 4'b1111, '0);
    lsu_push(32'h2000_0104, 1'b0, 4'b1111, '0);
    lsu_push(32'h3000_0008, 1'b0, 4'b1111, '0);
    run_lsu_queue();
  endtask

  task automatic ram_contention();
    region_pkg::word_t exp_rd;
    region_pkg::word_t rd;
    test_name = "contention";
    exp_rd = ram_ref[ram_index(LOCAL_BASE + 'h14)];
    s_psel_i    <= 1'b1;
    s_penable_i <= 1'b0;
    s_paddr_i   <= 'h300;
    s_pwrite_i  <= 1'b1;
    s_pwdata_i  <= 32'h5566_7788;
    s_pstrb_i   <= 4'b1111;
    @(posedge clk);
    // APB memory request and processor request share this cycle
    s_penable_i <= 1'b1;
    lsu_req_i   <= 1'b1;
    lsu_addr_i  <= LOCAL_BASE + 'h14;
    lsu_we_i    <= 1'b0;
    lsu_be_i    <= 4'b1111;
    lsu_wdata_i <= '0;
    @(posedge clk);
    if (lsu_gnt_o)
      report_failure("processor was granted while the APB port used the RAM");
    if (s_pready_o)
      report_failure("pready came in the first access cycle");
    @(posedge clk);
    if (!s_pready_o)
      report_failure("pready missing in the second access cycle");
    if (!lsu_gnt_o)
      report_failure("processor was not granted after the APB access");
    s_psel_i    <= 1'b0;
    s_penable_i <= 1'b0;
    lsu_req_i   <= 1'b0;
    ram_ref[ram_index('h300)] = 32'h5566_7788;
    @(posedge clk);
    if (!lsu_rvalid_o)
      report_failure("rvalid missing one cycle after the delayed grant");
    else
      compare_word("delayed read data", exp_rd, lsu_rdata_o);
    lsu_push(LOCAL_BASE + 'h300, 1'b0, 4'b1111, '0);
    run_lsu_queue();
    apb_xfer('h300, 1'b0, '0, 4'b0000, rd);
    compare_word("APB read data", 32'h5566_7788, rd);
  endtask

  task automatic response_order();
    test_name = "order";
    lsu_push(32'h2000_0104, 1'b0, 4'b1111, '0);
    lsu_push(LOCAL_BASE + 'h18, 1'b0, 4'b1111, '0);
    run_lsu_queue();
  endtask

  initial
  begin
    rst_n       = 1'b0;
    lsu_req_i   = 1'b0;
    lsu_addr_i  = '0;
    lsu_we_i    = 1'b0;
    lsu_be_i    = '0;
    lsu_wdata_i = '0;
    s_psel_i    = 1'b0;
    s_penable_i = 1'b0;
    s_paddr_i   = '0;
    s_pwrite_i  = 1'b0;
    s_pwdata_i  = '0;
    s_pstrb_i   = '0;
    m_prdata_i  = '0;
    m_pready_i  = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    local_ram_bytes();
    shared_memory();
    external_region();
    ram_contention();
    response_order();
    @(posedge clk);
    $display("run complete: %0d errors", errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/mem_region_top.sv
// top level of the memory region: processor data port, local data RAM, APB slave and master
`timescale 1ns/1ps
`default_nettype none

module mem_region_top #(
  parameter int                                 DATA_RAM_SIZE = 4096,
  parameter logic [region_pkg::REGION_HI_W-1:0] LOCAL_REGION  = 12'h001
) (
  input  logic               clk,
  input  logic               rst_n,
  // processor data port
  input  logic               lsu_req_i,
  output logic               lsu_gnt_o,
  output logic               lsu_rvalid_o,
  input  region_pkg::addr_t  lsu_addr_i,
  input  logic               lsu_we_i,
  input  region_pkg::strb_t  lsu_be_i,
  input  region_pkg::word_t  lsu_wdata_i,
  output region_pkg::word_t  lsu_rdata_o,
  // APB slave into the RAM
  input  logic               s_psel_i,
  input  logic               s_penable_i,
  input  region_pkg::addr_t  s_paddr_i,
  input  logic               s_pwrite_i,
  input  region_pkg::word_t  s_pwdata_i,
  input  region_pkg::strb_t  s_pstrb_i,
  output region_pkg::word_t  s_prdata_o,
  output logic               s_pready_o,
  // APB master out
  output logic               m_psel_o,
  output logic               m_penable_o,
  output region_pkg::addr_t  m_paddr_o,
  output logic               m_pwrite_o,
  output region_pkg::word_t  m_pwdata_o,
  output region_pkg::strb_t  m_pstrb_o,
  input  region_pkg::word_t  m_prdata_i,
  input  logic               m_pready_i
);

  localparam int IDX_W = $clog2(DATA_RAM_SIZE / region_pkg::STRB_W);

  // demux to arbiter
  logic              ram_req;
  logic              ram_gnt;
  logic              ram_rvalid;
  region_pkg::word_t ram_rdata;
  // demux to bridge
  logic              ext_req;
  logic              ext_gnt;
  logic              ext_rvalid;
  region_pkg::word_t ext_rdata;
  // APB port to arbiter
  logic              bus_req;
  region_pkg::addr_t bus_addr;
  logic              bus_we;
  region_pkg::strb_t bus_be;
  region_pkg::word_t bus_wdata;
  region_pkg::word_t bus_rdata;
  // arbiter to RAM
  logic              sram_en;
  logic [IDX_W-1:0]  sram_idx;
  logic              sram_we;
  region_pkg::strb_t sram_be;
  region_pkg::word_t sram_wdata;
  region_pkg::word_t sram_rdata;

  lsu_demux #(
    .LOCAL_REGION (LOCAL_REGION)
  ) lsu_demux_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ram_req_o    (ram_req),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .ext_req_o    (ext_req),
    .ext_gnt_i    (ext_gnt),
    .ext_rvalid_i (ext_rvalid),
    .ext_rdata_i  (ext_rdata)
  );

  apb_mem_port apb_mem_port_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_psel_i    (s_psel_i),
    .s_penable_i (s_penable_i),
    .s_paddr_i   (s_paddr_i),
    .s_pwrite_i  (s_pwrite_i),
    .s_pwdata_i  (s_pwdata_i),
    .s_pstrb_i   (s_pstrb_i),
    .s_prdata_o  (s_prdata_o),
    .s_pready_o  (s_pready_o),
    .mem_req_o   (bus_req),
    .mem_addr_o  (bus_addr),
    .mem_we_o    (bus_we),
    .mem_be_o    (bus_be),
    .mem_wdata_o (bus_wdata),
    .mem_rdata_i (bus_rdata)
  );

  ram_arbiter #(
    .DATA_RAM_SIZE (DATA_RAM_SIZE)
  ) ram_arbiter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .p0_req_i    (bus_req),
    .p0_addr_i   (bus_addr),
    .p0_we_i     (bus_we),
    .p0_be_i     (bus_be),
    .p0_wdata_i  (bus_wdata),
    .p0_rdata_o  (bus_rdata),
    .p1_req_i    (ram_req),
    .p1_addr_i   (lsu_addr_i),
    .p1_we_i     (lsu_we_i),
    .p1_be_i     (lsu_be_i),
    .p1_wdata_i  (lsu_wdata_i),
    .p1_gnt_o    (ram_gnt),
    .p1_rvalid_o (ram_rvalid),
    .p1_rdata_o  (ram_rdata),
    .ram_en_o    (sram_en),
    .ram_idx_o   (sram_idx),
    .ram_we_o    (sram_we),
    .ram_be_o    (sram_be),
    .ram_wdata_o (sram_wdata),
    .ram_rdata_i (sram_rdata)
  );

  data_sram #(
    .DATA_RAM_SIZE (DATA_RAM_SIZE)
  ) data_sram_inst (
    .clk     (clk),
    .en_i    (sram_en),
    .idx_i   (sram_idx),
    .we_i    (sram_we),
    .be_i    (sram_be),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  lsu_apb_bridge lsu_apb_bridge_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (ext_req),
    .addr_i      (lsu_addr_i),
    .we_i        (lsu_we_i),
    .be_i        (lsu_be_i),
    .wdata_i     (lsu_wdata_i),
    .gnt_o       (ext_gnt),
    .rvalid_o    (ext_rvalid),
    .rdata_o     (ext_rdata),
    .m_psel_o    (m_psel_o),
    .m_penable_o (m_penable_o),
    .m_paddr_o   (m_paddr_o),
    .m_pwrite_o  (m_pwrite_o),
    .m_pwdata_o  (m_pwdata_o),
    .m_pstrb_o   (m_pstrb_o),
    .m_prdata_i  (m_prdata_i),
    .m_pready_i  (m_pready_i)
  );

endmodule

`default_nettype wire

// File: logic/lsu_apb_bridge.sv
// converts a granted processor request into one APB master transfer
`timescale 1ns/1ps
`default_nettype none

module lsu_apb_bridge (
  input  logic               clk,
  input  logic               rst_n,
  // request side
  input  logic               req_i,
  input  region_pkg::addr_t  addr_i,
  input  logic               we_i,
  input  region_pkg::strb_t  be_i,
  input  region_pkg::word_t  wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output region_pkg::word_t  rdata_o,
  // APB master
  output logic               m_psel_o,
  output logic               m_penable_o,
  output region_pkg::addr_t  m_paddr_o,
  output logic               m_pwrite_o,
  output region_pkg::word_t  m_pwdata_o,
  output region_pkg::strb_t  m_pstrb_o,
  input  region_pkg::word_t  m_prdata_i,
  input  logic               m_pready_i
);

  region_pkg::apb_mst_state_e state_q;
  region_pkg::addr_t          addr_q;
  logic                       we_q;
  region_pkg::strb_t          be_q;
  region_pkg::word_t          wdata_q;

  // accept only from idle
  assign gnt_o = req_i && (state_q == region_pkg::MST_IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= region_pkg::MST_IDLE;
    else
    begin
      case (state_q)
        region_pkg::MST_IDLE:
          if (gnt_o)
            state_q <= region_pkg::MST_SETUP;
        region_pkg::MST_SETUP:
          state_q <= region_pkg::MST_ACCESS;
        region_pkg::MST_ACCESS:
          if (m_pready_i)
            state_q <= region_pkg::MST_IDLE;
        default:
          state_q <= region_pkg::MST_IDLE;
      endcase
    end
  end

  // request held stable for the whole transfer
  always_ff @(posedge clk)
  begin
    if (gnt_o)
    begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

  assign m_psel_o    = (state_q != region_pkg::MST_IDLE);
  assign m_penable_o = (state_q == region_pkg::MST_ACCESS);
  assign m_paddr_o   = addr_q;
  assign m_pwrite_o  = we_q;
  assign m_pwdata_o  = wdata_q;
  // strobes stay low on reads
  assign m_pstrb_o   = we_q ? be_q : '0;

  assign rvalid_o = m_penable_o && m_pready_i;
  assign rdata_o  = m_prdata_i;

endmodule

`default_nettype wire

// File: logic/data_sram.sv
// single-port word memory with byte enables and a registered one-cycle read
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
  parameter int  DATA_RAM_SIZE = 4096,
  localparam int WORDS         = DATA_RAM_SIZE / region_pkg::STRB_W,
  localparam int IDX_W         = $clog2(WORDS)
) (
  input  logic               clk,
  input  logic               en_i,
  input  logic [IDX_W-1:0]   idx_i,
  input  logic               we_i,
  input  region_pkg::strb_t  be_i,
  input  region_pkg::word_t  wdata_i,
  output region_pkg::word_t  rdata_o
);

  region_pkg::word_t mem_q [WORDS];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        // only enabled bytes change
        for (int b = 0; b < region_pkg::STRB_W; b++)
        begin
          if (be_i[b])
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      // read returns the word as it was before this write
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

`default_nettype wire

// File: logic/ram_arbiter.sv
// fixed-priority arbiter sharing the data RAM between the APB port and the processor port
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter #(
  parameter int  DATA_RAM_SIZE = 4096,
  localparam int IDX_W         = $clog2(DATA_RAM_SIZE / region_pkg::STRB_W)
) (
  input  logic               clk,
  input  logic               rst_n,
  // port 0, bus side, always accepted
  input  logic               p0_req_i,
  input  region_pkg::addr_t  p0_addr_i,
  input  logic               p0_we_i,
  input  region_pkg::strb_t  p0_be_i,
  input  region_pkg::word_t  p0_wdata_i,
  output region_pkg::word_t  p0_rdata_o,
  // port 1, processor side
  input  logic               p1_req_i,
  input  region_pkg::addr_t  p1_addr_i,
  input  logic               p1_we_i,
  input  region_pkg::strb_t  p1_be_i,
  input  region_pkg::word_t  p1_wdata_i,
  output logic               p1_gnt_o,
  output logic               p1_rvalid_o,
  output region_pkg::word_t  p1_rdata_o,
  // RAM side
  output logic               ram_en_o,
  output logic [IDX_W-1:0]   ram_idx_o,
  output logic               ram_we_o,
  output region_pkg::strb_t  ram_be_o,
  output region_pkg::word_t  ram_wdata_o,
  input  region_pkg::word_t  ram_rdata_i
);

  localparam int OFFS_W = $clog2(region_pkg::STRB_W);

  region_pkg::addr_t sel_addr;
  logic              p1_gnt_q;

  // bus port wins every conflict
  assign p1_gnt_o = p1_req_i && !p0_req_i;
  assign ram_en_o = p0_req_i || p1_req_i;

  always_comb
  begin
    if (p0_req_i)
    begin
      sel_addr    = p0_addr_i;
      ram_we_o    = p0_we_i;
      ram_be_o    = p0_be_i;
      ram_wdata_o = p0_wdata_i;
    end
    else
    begin
      sel_addr    = p1_addr_i;
      ram_we_o    = p1_we_i;
      ram_be_o    = p1_be_i;
      ram_wdata_o = p1_wdata_i;
    end
  end

  // byte address to word index
  assign ram_idx_o = sel_addr[OFFS_W +: IDX_W];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      p1_gnt_q <= 1'b0;
    else
      p1_gnt_q <= p1_gnt_o;
  end

  assign p1_rvalid_o = p1_gnt_q;

  // each port samples the shared read word only in its own response cycle
  assign p0_rdata_o = ram_rdata_i;
  assign p1_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

// File: logic/apb_mem_port.sv
// APB slave that turns each bus transfer into one RAM request with a single wait state
`timescale 1ns/1ps
`default_nettype none

module apb_mem_port (
  input  logic               clk,
  input  logic               rst_n,
  // APB slave
  input  logic               s_psel_i,
  input  logic               s_penable_i,
  input  region_pkg::addr_t  s_paddr_i,
  input  logic               s_pwrite_i,
  input  region_pkg::word_t  s_pwdata_i,
  input  region_pkg::strb_t  s_pstrb_i,
  output region_pkg::word_t  s_prdata_o,
  output logic               s_pready_o,
  // memory request
  output logic               mem_req_o,
  output region_pkg::addr_t  mem_addr_o,
  output logic               mem_we_o,
  output region_pkg::strb_t  mem_be_o,
  output region_pkg::word_t  mem_wdata_o,
  input  region_pkg::word_t  mem_rdata_i
);

  region_pkg::apb_slv_state_e state_q;

  // first access cycle issues the RAM request
  assign mem_req_o   = s_psel_i && s_penable_i && (state_q == region_pkg::SLV_IDLE);
  assign mem_addr_o  = s_paddr_i;
  assign mem_we_o    = s_pwrite_i;
  assign mem_be_o    = s_pstrb_i;
  assign mem_wdata_o = s_pwdata_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= region_pkg::SLV_IDLE;
    else
    begin
      case (state_q)
        region_pkg::SLV_IDLE:
          if (mem_req_o)
            state_q <= region_pkg::SLV_RESP;
        region_pkg::SLV_RESP:
          state_q <= region_pkg::SLV_IDLE;
        default:
          state_q <= region_pkg::SLV_IDLE;
      endcase
    end
  end

  // RAM word arrives the cycle after the request
  assign s_pready_o = (state_q == region_pkg::SLV_RESP);
  assign s_prdata_o = mem_rdata_i;

endmodule

`default_nettype wire

// File: logic/lsu_demux.sv
// steers processor load/store requests to the local RAM or the external bridge, returns responses
`timescale 1ns/1ps
`default_nettype none

module lsu_demux #(
  parameter logic [region_pkg::REGION_HI_W-1:0] LOCAL_REGION = 12'h001
) (
  input  logic               clk,
  input  logic               rst_n,
  // processor side
  input  logic               lsu_req_i,
  input  region_pkg::addr_t  lsu_addr_i,
  output logic               lsu_gnt_o,
  output logic               lsu_rvalid_o,
  output region_pkg::word_t  lsu_rdata_o,
  // local RAM side
  output logic               ram_req_o,
  input  logic               ram_gnt_i,
  input  logic               ram_rvalid_i,
  input  region_pkg::word_t  ram_rdata_i,
  // external side
  output logic               ext_req_o,
  input  logic               ext_gnt_i,
  input  logic               ext_rvalid_i,
  input  region_pkg::word_t  ext_rdata_i
);

  logic                  is_local;
  logic                  can_issue;
  logic                  pending_q;
  region_pkg::resp_src_e resp_src_q;

  // upper address bits pick the region
  assign is_local = (lsu_addr_i[region_pkg::ADDR_W-1 -: region_pkg::REGION_HI_W]
                     == LOCAL_REGION);

  // next request only once the outstanding response is back or returning now
  assign can_issue = !pending_q || lsu_rvalid_o;

  assign ram_req_o = lsu_req_i && can_issue && is_local;
  assign ext_req_o = lsu_req_i && can_issue && !is_local;

  assign lsu_gnt_o = (ram_req_o && ram_gnt_i) || (ext_req_o && ext_gnt_i);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending_q  <= 1'b0;
      resp_src_q <= region_pkg::RESP_RAM;
    end
    else if (lsu_gnt_o)
    begin
      pending_q <= 1'b1;
      if (is_local)
        resp_src_q <= region_pkg::RESP_RAM;
      else
        resp_src_q <= region_pkg::RESP_EXT;
    end
    else if (lsu_rvalid_o)
    begin
      pending_q <= 1'b0;
    end
  end

  // only one sink can answer at a time
  assign lsu_rvalid_o = ram_rvalid_i || ext_rvalid_i;
  assign lsu_rdata_o  = (resp_src_q == region_pkg::RESP_EXT) ? ext_rdata_i : ram_rdata_i;

endmodule

`default_nettype wire

// File: logic/region_pkg.sv
// shared widths, word types and state enums for the memory region RTL and its testbench
`default_nettype none

package region_pkg;

  // data path and address widths
  localparam int WORD_W      = 32;
  localparam int ADDR_W      = 32;
  localparam int STRB_W      = WORD_W / 8;
  localparam int REGION_HI_W = 12;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;

  // source of the next processor response
  typedef enum logic [0:0] {
    RESP_RAM,
    RESP_EXT
  } resp_src_e;

  // APB slave port into the RAM
  typedef enum logic [0:0] {
    SLV_IDLE,
    SLV_RESP
  } apb_slv_state_e;

  // APB master bridge
  typedef enum logic [1:0] {
    MST_IDLE,
    MST_SETUP,
    MST_ACCESS
  } apb_mst_state_e;

endpackage

`default_nettype wire
